/* Makefile */
VERILATOR ?= verilator
TOP       := tb_flop_ram
FILELIST  := verilog.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* common/flop_ram_pkg.sv */
// Shared geometry, latency constants and types for the flop RAM, imported by RTL and testbench
package flop_ram_pkg;

  // ------------------------------------------------------------
  // RAM geometry
  // ------------------------------------------------------------

  // Total words in the RAM
  localparam int DEPTH = 16;
  // Independent storage tiles along the depth dimension
  localparam int TILES = 4;
  localparam int TILE_DEPTH = DEPTH / TILES;
  localparam int DATA_WIDTH = 8;
  localparam int ADDR_WIDTH = $clog2(DEPTH);
  // Low address bits that stay with the tile
  localparam int TILE_ADDR_WIDTH = $clog2(TILE_DEPTH);

  // ------------------------------------------------------------
  // Decoder tree shape
  // ------------------------------------------------------------

  // TILES must equal FORKS_PER_LEVEL ** DECODE_LEVELS
  localparam int DECODE_LEVELS = 2;
  localparam int FORKS_PER_LEVEL = 2;

  // ------------------------------------------------------------
  // Latencies in cycles
  // ------------------------------------------------------------

  // One register per decoder level
  localparam int DECODE_LATENCY = DECODE_LEVELS;
  // Decode, then tile read register, then read mux register
  localparam int RD_LATENCY = DECODE_LATENCY + 2;
  // Decode, then the commit edge in the tile
  localparam int WR_LATENCY = DECODE_LATENCY + 1;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [TILE_ADDR_WIDTH-1:0] tile_addr_t;

endpackage : flop_ram_pkg

/* logic/flop_ram_1r1w.sv */
// Top level of the tiled 1R1W flop RAM, joins decoders, write data delay, tiles and read mux
`timescale 1ns/10ps

module flop_ram_1r1w
  import flop_ram_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  // Write port, one write per cycle, no back-pressure
  input  logic  wr_valid,
  input  addr_t wr_addr,
  input  word_t wr_data,
  // Read port, one read per cycle, no back-pressure
  input  logic  rd_valid,
  input  addr_t rd_addr,
  output logic  rd_data_valid,
  output word_t rd_data
);

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------

  logic       [TILES-1:0] wr_tile_valid;
  tile_addr_t [TILES-1:0] wr_tile_addr;
  logic       [TILES-1:0] rd_tile_valid;
  tile_addr_t [TILES-1:0] rd_tile_addr;

  ram_addr_decoder u_wr_decoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_valid (wr_valid),
    .addr       (wr_addr),
    .tile_valid (wr_tile_valid),
    .tile_addr  (wr_tile_addr)
  );

  ram_addr_decoder u_rd_decoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_valid (rd_valid),
    .addr       (rd_addr),
    .tile_valid (rd_tile_valid),
    .tile_addr  (rd_tile_addr)
  );

  // ------------------------------------------------------------
  // Write data delay line
  // ------------------------------------------------------------

  // Matches the decoder latency so data and tile valid line up
  word_t wr_data_pipe [DECODE_LATENCY];

  always_ff @(posedge clk) begin
    wr_data_pipe[0] <= wr_data;
    for (int i = 1; i < DECODE_LATENCY; i++) begin
      wr_data_pipe[i] <= wr_data_pipe[i-1];
    end
  end

  // ------------------------------------------------------------
  // Storage tiles
  // ------------------------------------------------------------

  logic  [TILES-1:0] tile_rd_valid;
  word_t [TILES-1:0] tile_rd_word;

  // Write data is broadcast, the one-hot valid picks the tile
  for (genvar t = 0; t < TILES; t++) begin : gen_tile
    ram_tile u_ram_tile (
      .clk           (clk),
      .rst_n         (rst_n),
      .wr_valid      (wr_tile_valid[t]),
      .wr_addr       (wr_tile_addr[t]),
      .wr_data       (wr_data_pipe[DECODE_LATENCY-1]),
      .rd_valid      (rd_tile_valid[t]),
      .rd_addr       (rd_tile_addr[t]),
      .rd_word_valid (tile_rd_valid[t]),
      .rd_word       (tile_rd_word[t])
    );
  end

  // ------------------------------------------------------------
  // Read return
  // ------------------------------------------------------------

  ram_read_mux u_ram_read_mux (
    .clk           (clk),
    .rst_n         (rst_n),
    .tile_rd_valid (tile_rd_valid),
    .tile_rd_word  (tile_rd_word),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  // End to end read latency through decoder, tile and mux
  a_rd_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_valid |-> ##RD_LATENCY rd_data_valid
  );

endmodule : flop_ram_1r1w

/* logic/ram_read_mux.sv */
// Registered one-hot mux that returns the read word of whichever tile answered
`timescale 1ns/10ps

module ram_read_mux
  import flop_ram_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // One response strobe and word per tile
  input  logic  [TILES-1:0]     tile_rd_valid,
  input  word_t [TILES-1:0]     tile_rd_word,
  output logic                  rd_data_valid,
  output word_t                 rd_data
);

  // ------------------------------------------------------------
  // AND-OR select
  // ------------------------------------------------------------

  word_t mux_word;
  logic  any_valid;

  // Words of idle tiles are masked out
  always_comb begin
    mux_word = '0;
    for (int t = 0; t < TILES; t++) begin
      if (tile_rd_valid[t]) begin
        mux_word = mux_word | tile_rd_word[t];
      end
    end
  end

  assign any_valid = |tile_rd_valid;

  // ------------------------------------------------------------
  // Output registers
  // ------------------------------------------------------------

  // Data holds its last value between reads
  always_ff @(posedge clk) begin
    if (any_valid) begin
      rd_data <= mux_word;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= any_valid;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Tiles answer one at a time, otherwise the OR corrupts the word
  a_tile_rd_onehot0: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(tile_rd_valid)
  );

endmodule : ram_read_mux

/* logic/ram_tile.sv */
// Storage tile of flop words that the top level instantiates once per tile of the RAM
`timescale 1ns/10ps

module ram_tile
  import flop_ram_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Write port driven by the write decoder leaf of this tile
  input  logic       wr_valid,
  input  tile_addr_t wr_addr,
  input  word_t      wr_data,
  // Read port driven by the read decoder leaf of this tile
  input  logic       rd_valid,
  input  tile_addr_t rd_addr,
  output logic       rd_word_valid,
  output word_t      rd_word
);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  // TILE_DEPTH words of flop storage
  word_t mem [TILE_DEPTH];

  // Commit on the edge where the decoded write arrives
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------

  // Array is sampled before this edge's write takes effect
  // so a same-edge collision returns the old word
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      rd_word <= mem[rd_addr];
    end
  end

  // Read response strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_word_valid <= 1'b0;
    end else begin
      rd_word_valid <= rd_valid;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Response comes exactly one cycle after the decoded read
  a_rd_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_valid |=> rd_word_valid
  );

endmodule : ram_tile

/* ram_addr_decoder/ram_addr_decoder.sv */
// Pipelined tree of decoder stages that steers one address to a one-hot tile valid and local address
`timescale 1ns/10ps

module ram_addr_decoder
  import flop_ram_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    addr_valid,
  input  addr_t                   addr,
  output logic       [TILES-1:0]  tile_valid,
  output tile_addr_t [TILES-1:0]  tile_addr
);

  // Address bits consumed by each level
  localparam int SEL_WIDTH = $clog2(FORKS_PER_LEVEL);

  // ------------------------------------------------------------
  // Decoder tree
  // ------------------------------------------------------------

  // Level l holds FORKS_PER_LEVEL ** l stages
  // Each level strips SEL_WIDTH high bits off the address
  // Node n of a level feeds children n*FORKS_PER_LEVEL and up in the next level
  // so the tile index comes out equal to the high address bits
  for (genvar l = 0; l < DECODE_LEVELS; l++) begin : gen_level
    localparam int NODES_IN = FORKS_PER_LEVEL ** l;
    localparam int NODES_OUT = NODES_IN * FORKS_PER_LEVEL;
    localparam int IN_W = ADDR_WIDTH - l * SEL_WIDTH;
    localparam int OUT_W = IN_W - SEL_WIDTH;

    // Registered outputs of every stage at this level
    logic [NODES_OUT-1:0]            node_valid;
    logic [NODES_OUT-1:0][OUT_W-1:0] node_addr;

    for (genvar n = 0; n < NODES_IN; n++) begin : gen_node
      logic            stage_in_valid;
      logic [IN_W-1:0] stage_in_addr;

      if (l == 0) begin : gen_root
        // Root takes the full request
        assign stage_in_valid = addr_valid;
        assign stage_in_addr  = addr;
      end else begin : gen_inner
        // Inner stages take one child of the level above
        assign stage_in_valid = gen_level[l-1].node_valid[n];
        assign stage_in_addr  = gen_level[l-1].node_addr[n];
      end

      ram_addr_decoder_stage #(
        .IN_ADDR_WIDTH (IN_W),
        .FORKS         (FORKS_PER_LEVEL)
      ) u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (stage_in_valid),
        .in_addr   (stage_in_addr),
        .out_valid (node_valid[n*FORKS_PER_LEVEL +: FORKS_PER_LEVEL]),
        .out_addr  (node_addr[n*FORKS_PER_LEVEL +: FORKS_PER_LEVEL])
      );
    end
  end

  // ------------------------------------------------------------
  // Leaves
  // ------------------------------------------------------------

  // Last level has one output per tile, its address already tile-local
  assign tile_valid = gen_level[DECODE_LEVELS-1].node_valid;
  assign tile_addr  = gen_level[DECODE_LEVELS-1].node_addr;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Every request reaches exactly one tile after the full tree latency
  a_request_hits_one_tile: assert property (
    @(posedge clk) disable iff (!rst_n)
    addr_valid |-> ##DECODE_LATENCY $onehot(tile_valid)
  );

  // No tile is selected without a request
  a_no_spurious_tile: assert property (
    @(posedge clk) disable iff (!rst_n)
    !addr_valid |-> ##DECODE_LATENCY (tile_valid == '0)
  );

endmodule : ram_addr_decoder

/* ram_addr_decoder/ram_addr_decoder_stage.sv */
// Registered decode level that the decoder tree instantiates once per node to fork an address
`timescale 1ns/10ps

module ram_addr_decoder_stage #(
  // Address bits seen by this level
  parameter int IN_ADDR_WIDTH = 4,
  // Children per stage as a power of two of at least 2
  parameter int FORKS = 2,
  localparam int SEL_WIDTH = $clog2(FORKS),
  localparam int OUT_ADDR_WIDTH = IN_ADDR_WIDTH - SEL_WIDTH
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  in_valid,
  input  logic [IN_ADDR_WIDTH-1:0]              in_addr,
  output logic [FORKS-1:0]                      out_valid,
  output logic [FORKS-1:0][OUT_ADDR_WIDTH-1:0]  out_addr
);

  // ------------------------------------------------------------
  // Fork select
  // ------------------------------------------------------------

  // Top bits of the incoming address pick the child
  logic [SEL_WIDTH-1:0] fork_sel;
  logic [FORKS-1:0]     fork_onehot;

  assign fork_sel = in_addr[IN_ADDR_WIDTH-1 -: SEL_WIDTH];

  always_comb begin
    fork_onehot = '0;
    // Only the selected child sees the valid
    fork_onehot[fork_sel] = in_valid;
  end

  // ------------------------------------------------------------
  // Output registers
  // ------------------------------------------------------------

  // Registered child valids
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= '0;
    end else begin
      out_valid <= fork_onehot;
    end
  end

  // Remaining low bits go to every child
  // Children ignore the address unless their valid is set
  always_ff @(posedge clk) begin
    if (in_valid) begin
      for (int f = 0; f < FORKS; f++) begin
        out_addr[f] <= in_addr[OUT_ADDR_WIDTH-1:0];
      end
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Never more than one child active
  a_out_valid_onehot0: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(out_valid)
  );

endmodule : ram_addr_decoder_stage

/* tests/ram_checker.sv */
// Testbench checker, keeps a model of the RAM and compares every read response with it
`timescale 1ns/10ps

module ram_checker
  import flop_ram_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  wr_valid,
  input addr_t wr_addr,
  input word_t wr_data,
  input logic  rd_valid,
  input addr_t rd_addr,
  input logic  rd_data_valid,
  input word_t rd_data
);

  // One outstanding read, tagged with the cycle it was issued in
  typedef struct packed {
    int    issue;
    addr_t addr;
    word_t data;
    logic  known;
  } expect_t;

  // ------------------------------------------------------------
  // Model state
  // ------------------------------------------------------------

  word_t   model_mem [DEPTH];
  // Words never written have no defined value to compare
  logic    model_known [DEPTH];
  expect_t expect_q [$];

  // Counters read by the testbench top
  int cycle_count = 0;
  int error_count = 0;
  int check_count = 0;
  int outstanding = 0;

  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      model_known[a] = 1'b0;
    end
  end

  // ------------------------------------------------------------
  // Compare and update, once per rising edge
  // ------------------------------------------------------------

  always @(posedge clk) begin : compare_proc
    expect_t head;
    expect_t req;
    cycle_count++;
    if (!rst_n) begin
      expect_q.delete();
    end else begin
      // Response side first
      if (rd_data_valid) begin
        if (expect_q.size() == 0) begin
          $display("Error at time %0t: rd_data_valid is high with no read outstanding", $time);
          error_count++;
        end else begin
          head = expect_q.pop_front();
          check_count++;
          if (cycle_count != head.issue + RD_LATENCY) begin
            $display("FAILED at %0t: read of addr %0h from cycle %0d answered in cycle %0d",
                     $time, head.addr, head.issue, cycle_count);
            error_count++;
          end else if (head.known && rd_data !== head.data) begin
            $display("FAILED at %0t: read of addr %0h returned %0h, expected %0h",
                     $time, head.addr, rd_data, head.data);
            error_count++;
          end
        end
      end else if (expect_q.size() != 0 && cycle_count >= expect_q[0].issue + RD_LATENCY) begin
        // Response is overdue
        head = expect_q.pop_front();
        $display("Error at time %0t: read of addr %0h from cycle %0d got no response",
                 $time, head.addr, head.issue);
        error_count++;
      end
      // Read looks up the model before this cycle's write lands
      if (rd_valid) begin
        req.issue = cycle_count;
        req.addr  = rd_addr;
        req.data  = model_mem[rd_addr];
        req.known = model_known[rd_addr];
        expect_q.push_back(req);
      end
      if (wr_valid) begin
        model_mem[wr_addr]   = wr_data;
        model_known[wr_addr] = 1'b1;
      end
    end
    outstanding = expect_q.size();
  end

endmodule : ram_checker

/* tests/tb_flop_ram.sv */
// Testbench top for the tiled flop RAM, runs seeded random tests and prints one line per test
`timescale 1ns/10ps

module tb_flop_ram
  import flop_ram_pkg::*;
();

  logic  clk;
  logic  rst_n;
  logic  wr_valid;
  addr_t wr_addr;
  word_t wr_data;
  logic  rd_valid;
  addr_t rd_addr;
  logic  rd_data_valid;
  word_t rd_data;

  // Per-test bookkeeping
  int timeout_count;
  int test_count;
  int errors_before;
  int checks_before;
  int total_errors;

  // 10 ns clock
  always #5 clk = ~clk;

  flop_ram_1r1w u_flop_ram_1r1w (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid      (wr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_valid      (rd_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  ram_checker u_ram_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid      (wr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_valid      (rd_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  // ------------------------------------------------------------
  // Drive helpers
  // ------------------------------------------------------------

  // One cycle of both ports, applied just after the rising edge
  task automatic drive_cycle(input logic wv, input addr_t wa, input word_t wd,
                             input logic rv, input addr_t ra);
    @(posedge clk);
    wr_valid <= wv;
    wr_addr  <= wa;
    wr_data  <= wd;
    rd_valid <= rv;
    rd_addr  <= ra;
  endtask

  task automatic drive_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      drive_cycle(1'b0, '0, '0, 1'b0, '0);
    end
  endtask

  task automatic start_test();
    errors_before = u_ram_checker.error_count + timeout_count;
    checks_before = u_ram_checker.check_count;
  endtask

  // Let the pipeline drain, then report the test
  task automatic finish_test(input string name);
    int cycles;
    int errors;
    drive_idle(1);
    cycles = 0;
    @(negedge clk);
    while (u_ram_checker.outstanding != 0 && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (u_ram_checker.outstanding != 0) begin
      $display("Timeout in test %s: %0d reads never answered", name, u_ram_checker.outstanding);
      timeout_count++;
    end
    errors = u_ram_checker.error_count + timeout_count - errors_before;
    test_count++;
    $display("Test %0d %s: %0d reads checked, %0d errors", test_count, name,
             u_ram_checker.check_count - checks_before, errors);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    void'($urandom(32'h3e85_0163));
    clk           = 1'b0;
    rst_n         = 1'b0;
    wr_valid      = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    rd_valid      = 1'b0;
    rd_addr       = '0;
    timeout_count = 0;
    test_count    = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Quiet after reset, and during writes with no reads
    start_test();
    drive_idle(10);
    for (int i = 0; i < 12; i++) begin
      drive_cycle(1'b1, addr_t'($urandom_range(DEPTH-1)), word_t'($urandom), 1'b0, '0);
    end
    finish_test("idle quietness");

    start_test();
    for (int a = 0; a < DEPTH; a++) begin
      drive_cycle(1'b1, addr_t'(a), word_t'($urandom), 1'b0, '0);
    end
    for (int a = 0; a < DEPTH; a++) begin
      drive_cycle(1'b0, '0, '0, 1'b1, addr_t'(a));
    end
    finish_test("fill and read back");

    // Both ports busy about three cycles in four
    start_test();
    for (int i = 0; i < 500; i++) begin
      drive_cycle($urandom_range(3) != 0, addr_t'($urandom_range(DEPTH-1)), word_t'($urandom),
                  $urandom_range(3) != 0, addr_t'($urandom_range(DEPTH-1)));
    end
    finish_test("random traffic");

    // Same address on both ports, the read must see the old word
    start_test();
    for (int a = 0; a < DEPTH; a++) begin
      drive_cycle(1'b1, addr_t'(a), word_t'($urandom), 1'b1, addr_t'(a));
    end
    finish_test("same-cycle collision");

    // Read one cycle behind the write, every tile in turn
    start_test();
    for (int a = 0; a < DEPTH; a++) begin
      drive_cycle(1'b1, addr_t'(a), word_t'($urandom), 1'b0, '0);
      drive_cycle(1'b0, '0, '0, 1'b1, addr_t'(a));
    end
    finish_test("read after write");

    // Checker holds each response to exactly RD_LATENCY
    start_test();
    for (int i = 0; i < 32; i++) begin
      drive_cycle(1'b0, '0, '0, 1'b1, addr_t'($urandom_range(DEPTH-1)));
    end
    finish_test("back-to-back latency");

    total_errors = u_ram_checker.error_count + timeout_count;
    $display("Tests: %0d, reads checked: %0d, errors: %0d", test_count,
             u_ram_checker.check_count, total_errors);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_flop_ram

/* verilog.f */
common/flop_ram_pkg.sv
ram_addr_decoder/ram_addr_decoder_stage.sv
ram_addr_decoder/ram_addr_decoder.sv
logic/ram_tile.sv
logic/ram_read_mux.sv
logic/flop_ram_1r1w.sv
tests/ram_checker.sv
tests/tb_flop_ram.sv
